// File: hw/sched_cfg.svh
// ##########################################################################
// Slot scheduler configuration: port, core and slot counts, stream widths
// ##########################################################################
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

`define SCHED_IF_COUNT      2
`define SCHED_CORE_COUNT    4
`define SCHED_SLOT_COUNT    8
`define SCHED_DATA_WIDTH    64
`define SCHED_KEEP_WIDTH    (`SCHED_DATA_WIDTH / 8)

// Slots are numbered from 1, so the extra bit also fits a full count
`define SCHED_SLOT_WIDTH    ($clog2(`SCHED_SLOT_COUNT + 1))
`define SCHED_CORE_ID_WIDTH ($clog2(`SCHED_CORE_COUNT))
`define SCHED_PORT_WIDTH    ($clog2(`SCHED_IF_COUNT))
`define SCHED_TAG_WIDTH     ((`SCHED_SLOT_WIDTH > 5) ? `SCHED_SLOT_WIDTH : 5)

`endif

// File: hw/sched_pkg.sv
// ##########################################################################
// Slot scheduler types: descriptors, port states, host commands, messages
// ##########################################################################
`include "sched_cfg.svh"

package sched_pkg;

  // Core index above a zero-extended slot tag
  typedef struct packed {
    logic [`SCHED_CORE_ID_WIDTH-1:0] core;
    logic [`SCHED_TAG_WIDTH-1:0]     tag;
  } id_tag_t;

  typedef enum logic [1:0] {
    STALL = 2'd0,
    FIRST = 2'd1,
    WAIT  = 2'd2,
    MID   = 2'd3
  } port_state_t;

  // Bit 30 tells which view applies
  typedef union packed {
    struct packed {
      logic                             wr;
      logic                             if_sel;
      logic                             sched;
      logic [24-`SCHED_CORE_ID_WIDTH:0] rsvd;
      logic [`SCHED_CORE_ID_WIDTH-1:0]  core;
      logic [3:0]                       reg_num;
    } core;
    struct packed {
      logic                          wr;
      logic                          if_sel;
      logic                          sched;
      logic [24-`SCHED_PORT_WIDTH:0] rsvd;
      logic [`SCHED_PORT_WIDTH-1:0]  port;
      logic [3:0]                    reg_num;
    } intf;
  } host_cmd_t;

  typedef struct packed {
    logic [3:0]                    msg_type;
    logic [15-`SCHED_SLOT_WIDTH:0] rsvd_hi;
    logic [`SCHED_SLOT_WIDTH-1:0]  slot;
    logic [15:0]                   rsvd_lo;
  } slot_msg_t;

endpackage

// File: hw/slot_msg_decode.sv
// ##########################################################################
// Slot message decode: registered per-core init and return strobes
// ##########################################################################
`include "sched_cfg.svh"

module slot_msg_decode
  import sched_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_r,
  input  slot_msg_t                       ctrl_s_tdata,
  input  logic                            ctrl_s_tvalid,
  input  logic [`SCHED_CORE_ID_WIDTH-1:0] ctrl_s_tuser,
  output logic [`SCHED_CORE_COUNT-1:0]    init_v,
  output logic [`SCHED_CORE_COUNT-1:0]    ret_v,
  output logic [`SCHED_SLOT_WIDTH-1:0]    slot_value
);

  localparam int N  = `SCHED_CORE_COUNT;
  localparam int CW = `SCHED_CORE_ID_WIDTH;

  localparam logic [3:0] MSG_RETURN = 4'd0;
  localparam logic [3:0] MSG_INIT   = 4'd3;

  logic is_init;
  logic is_ret;

  assign is_init = ctrl_s_tvalid && (ctrl_s_tdata.msg_type == MSG_INIT);
  assign is_ret  = ctrl_s_tvalid && (ctrl_s_tdata.msg_type == MSG_RETURN);

  // Strobe only the keeper of the source core
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v <= '0;
      ret_v  <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        init_v[i] <= is_init && (ctrl_s_tuser == CW'(i));
        ret_v[i]  <= is_ret && (ctrl_s_tuser == CW'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    slot_value <= ctrl_s_tdata.slot;
  end

endmodule

// File: hw/slot_keeper.sv
// ##########################################################################
// Free-slot FIFO of one core with init fill, return, pop and flush
// ##########################################################################
`include "sched_cfg.svh"

module slot_keeper (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic                         flush,
  input  logic                         init_v,
  input  logic                         ret_v,
  input  logic [`SCHED_SLOT_WIDTH-1:0] slot_value,
  input  logic                         pop,
  output logic [`SCHED_SLOT_WIDTH-1:0] head_slot,
  output logic                         head_valid,
  output logic [`SCHED_SLOT_WIDTH-1:0] slot_count
);

  localparam int N    = `SCHED_SLOT_COUNT;
  localparam int SW   = `SCHED_SLOT_WIDTH;
  localparam int PTRW = $clog2(N);

  logic [SW-1:0]   mem [N];
  logic [PTRW-1:0] rd_ptr;
  logic [PTRW-1:0] wr_ptr;
  logic [SW-1:0]   fill;
  logic            push;
  logic            do_pop;

  // Init larger than the pool is clipped
  assign fill       = (slot_value > SW'(N)) ? SW'(N) : slot_value;
  assign head_valid = (slot_count != '0);
  assign head_slot  = mem[rd_ptr];
  assign push       = ret_v && (slot_count != SW'(N));
  assign do_pop     = pop && head_valid;

  // Init rewrites the whole pool as slots 1 to N
  always_ff @(posedge clk) begin
    if (init_v) begin
      for (int i = 0; i < N; i++)
        mem[i] <= SW'(i + 1);
    end else if (push) begin
      mem[wr_ptr] <= slot_value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
    end else if (init_v) begin
      rd_ptr     <= '0;
      wr_ptr     <= fill[PTRW-1:0];
      slot_count <= fill;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      slot_count <= slot_count + SW'(push) - SW'(do_pop);
    end
  end

endmodule

// File: hw/core_selector.sv
// ##########################################################################
// Core selector: accepting core with the most free slots, and its pop
// ##########################################################################
`include "sched_cfg.svh"

module core_selector (
  input  logic [`SCHED_CORE_COUNT-1:0]                    income_cores,
  input  logic [`SCHED_CORE_COUNT*`SCHED_SLOT_WIDTH-1:0]  slot_counts,
  input  logic [`SCHED_CORE_COUNT*`SCHED_SLOT_WIDTH-1:0]  head_slots,
  input  logic                                            desc_pop,
  output logic [`SCHED_CORE_ID_WIDTH-1:0]                 sel_core,
  output logic [`SCHED_SLOT_WIDTH-1:0]                    sel_slot,
  output logic                                            sel_valid,
  output logic [`SCHED_CORE_COUNT-1:0]                    core_pop
);

  localparam int N  = `SCHED_CORE_COUNT;
  localparam int SW = `SCHED_SLOT_WIDTH;
  localparam int CW = `SCHED_CORE_ID_WIDTH;

  // Heap-ordered tree, leaves N to 2N-1 are the cores
  logic [2*N-1:1] node_v;
  logic [SW-1:0]  node_cnt [1:2*N-1];
  logic [CW-1:0]  node_idx [1:2*N-1];

  always_comb begin
    logic take_left;
    for (int i = 0; i < N; i++) begin
      node_v[N+i]   = income_cores[i] && (slot_counts[i*SW +: SW] != '0);
      node_cnt[N+i] = slot_counts[i*SW +: SW];
      node_idx[N+i] = CW'(i);
    end
    // Left child holds the lower index and wins ties
    for (int k = N - 1; k >= 1; k--) begin
      take_left   = node_v[2*k] &&
                    (!node_v[2*k+1] || (node_cnt[2*k] >= node_cnt[2*k+1]));
      node_v[k]   = node_v[2*k] || node_v[2*k+1];
      node_cnt[k] = take_left ? node_cnt[2*k] : node_cnt[2*k+1];
      node_idx[k] = take_left ? node_idx[2*k] : node_idx[2*k+1];
    end
  end

  assign sel_valid = node_v[1];
  assign sel_core  = node_idx[1];
  assign sel_slot  = head_slots[sel_core*SW +: SW];
  assign core_pop  = desc_pop ? (N'(1) << sel_core) : '0;

endmodule

// File: hw/port_dispatcher.sv
// ##########################################################################
// Port dispatcher: per-port descriptor FSMs, round-robin requests, tagging
// ##########################################################################
`include "sched_cfg.svh"

module port_dispatcher
  import sched_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]  rx_tdata,
  input  logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0]  rx_tkeep,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tvalid,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tlast,
  output logic [`SCHED_IF_COUNT-1:0]                    rx_tready,
  output logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]  data_m_tdata,
  output logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0]  data_m_tkeep,
  output id_tag_t [`SCHED_IF_COUNT-1:0]                 data_m_tdest,
  output logic [`SCHED_IF_COUNT*`SCHED_PORT_WIDTH-1:0]  data_m_tuser,
  output logic [`SCHED_IF_COUNT-1:0]                    data_m_tvalid,
  output logic [`SCHED_IF_COUNT-1:0]                    data_m_tlast,
  input  logic [`SCHED_IF_COUNT-1:0]                    data_m_tready,
  input  logic [`SCHED_CORE_ID_WIDTH-1:0]               sel_core,
  input  logic [`SCHED_SLOT_WIDTH-1:0]                  sel_slot,
  input  logic                                          sel_valid,
  output logic                                          desc_pop,
  input  logic [`SCHED_IF_COUNT-1:0]                    release_desc,
  output port_state_t [`SCHED_IF_COUNT-1:0]             port_state,
  output id_tag_t [`SCHED_IF_COUNT-1:0]                 dest_r
);

  localparam int IF = `SCHED_IF_COUNT;
  localparam int PW = `SCHED_PORT_WIDTH;
  localparam int TW = `SCHED_TAG_WIDTH;

  logic [IF-1:0]    port_valid;
  logic [IF-1:0]    last_word;
  logic [IF-1:0]    not_stall;
  logic [IF-1:0]    desc_req;
  logic [IF-1:0]    desc_avail;
  logic             grant_v;
  logic [PW-1:0]    grant_idx;
  logic             next_v;
  logic [PW-1:0]    next_idx;
  id_tag_t          new_desc;
  id_tag_t [IF-1:0] dest_rr;

  assign port_valid    = rx_tvalid & rx_tready;
  assign last_word     = port_valid & rx_tlast;
  assign rx_tready     = data_m_tready & not_stall;
  assign data_m_tvalid = rx_tvalid & not_stall;
  assign data_m_tdata  = rx_tdata;
  assign data_m_tkeep  = rx_tkeep;
  assign data_m_tlast  = rx_tlast;
  assign desc_pop      = grant_v && sel_valid;
  assign new_desc      = '{core: sel_core, tag: TW'(sel_slot)};

  always_comb begin
    for (int p = 0; p < IF; p++) begin
      not_stall[p]  = (port_state[p] != STALL);
      desc_avail[p] = desc_pop && (grant_idx == PW'(p));
      // A port already holding the grant does not ask again
      desc_req[p]   = !(grant_v && (grant_idx == PW'(p))) &&
                      ((port_state[p] == STALL) || (port_state[p] == WAIT) ||
                       ((port_state[p] == FIRST) && port_valid[p]));
      data_m_tdest[p] = (port_state[p] == FIRST) ? dest_r[p] : dest_rr[p];
      data_m_tuser[p*PW +: PW] = PW'(p);
    end
  end

  // Round robin, search starts after the last granted port
  always_comb begin
    int cand;
    next_v   = 1'b0;
    next_idx = grant_idx;
    for (int off = IF; off >= 1; off--) begin
      cand = (int'(grant_idx) + off) % IF;
      if (desc_req[cand]) begin
        next_v   = 1'b1;
        next_idx = PW'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_v   <= 1'b0;
      grant_idx <= PW'(IF - 1);
    end else begin
      grant_v   <= next_v;
      grant_idx <= next_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int p = 0; p < IF; p++) begin
        port_state[p] <= STALL;
        dest_r[p]     <= '0;
      end
    end else begin
      for (int p = 0; p < IF; p++) begin
        case (port_state[p])
          STALL: begin
            if (desc_avail[p])
              port_state[p] <= FIRST;
          end
          FIRST: begin
            if (last_word[p])
              port_state[p] <= STALL;
            else if (port_valid[p])
              port_state[p] <= WAIT;
            else if (release_desc[p])
              port_state[p] <= STALL;
          end
          WAIT: begin
            if (desc_avail[p] && last_word[p])
              port_state[p] <= FIRST;
            else if (desc_avail[p])
              port_state[p] <= MID;
            else if (last_word[p])
              port_state[p] <= STALL;
          end
          MID: begin
            // Released descriptor is dropped, not used for the next packet
            if (last_word[p])
              port_state[p] <= release_desc[p] ? STALL : FIRST;
            else if (release_desc[p])
              port_state[p] <= WAIT;
          end
        endcase
        if (desc_avail[p])
          dest_r[p] <= new_desc;
      end
    end
  end

  // Hold the packet's tdest from its first word to tlast
  always_ff @(posedge clk) begin
    for (int p = 0; p < IF; p++) begin
      if ((port_state[p] == FIRST) && port_valid[p])
        dest_rr[p] <= dest_r[p];
    end
  end

endmodule

// File: hw/host_cmd_regs.sv
// ##########################################################################
// Host command decode, core masks, flush and release strobes, status reads
// ##########################################################################
`include "sched_cfg.svh"

module host_cmd_regs
  import sched_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  host_cmd_t                                     host_cmd,
  input  logic [31:0]                                   host_cmd_wr_data,
  input  logic                                          host_cmd_valid,
  output logic [31:0]                                   host_cmd_rd_data,
  output logic [`SCHED_CORE_COUNT-1:0]                  enabled_cores,
  output logic [`SCHED_CORE_COUNT-1:0]                  income_cores,
  output logic [`SCHED_CORE_COUNT-1:0]                  slots_flush,
  output logic [`SCHED_IF_COUNT-1:0]                    release_desc,
  input  logic [`SCHED_CORE_COUNT*`SCHED_SLOT_WIDTH-1:0] slot_counts,
  input  port_state_t [`SCHED_IF_COUNT-1:0]             port_state,
  input  id_tag_t [`SCHED_IF_COUNT-1:0]                 dest_r
);

  localparam int C  = `SCHED_CORE_COUNT;
  localparam int IF = `SCHED_IF_COUNT;
  localparam int SW = `SCHED_SLOT_WIDTH;
  localparam int CW = `SCHED_CORE_ID_WIDTH;
  localparam int TW = `SCHED_TAG_WIDTH;

  host_cmd_t   cmd_r;
  logic [31:0] wr_data_r;
  logic        wr_r;
  logic [4:0]  addr;
  id_tag_t     rd_desc;

  // Interface select bit on top of the register number
  assign addr    = {cmd_r.core.if_sel, cmd_r.core.reg_num};
  assign rd_desc = dest_r[cmd_r.intf.port];

  always_ff @(posedge clk) begin
    cmd_r     <= host_cmd;
    wr_data_r <= host_cmd_wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      release_desc  <= '0;
    end else begin
      wr_r         <= host_cmd_valid && host_cmd.core.wr && host_cmd.core.sched;
      slots_flush  <= '0;
      release_desc <= '0;
      if (wr_r) begin
        case (addr)
          5'h00: begin
            // Disabling a core also stops it taking packets
            enabled_cores <= wr_data_r[C-1:0];
            income_cores  <= income_cores & wr_data_r[C-1:0];
          end
          5'h01: income_cores <= wr_data_r[C-1:0] & enabled_cores;
          5'h02: slots_flush  <= wr_data_r[C-1:0];
          5'h12: release_desc <= wr_data_r[IF-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    case (addr)
      5'h00: host_cmd_rd_data <= 32'(enabled_cores);
      5'h01: host_cmd_rd_data <= 32'(income_cores);
      5'h03: host_cmd_rd_data <= 32'(slot_counts[cmd_r.core.core*SW +: SW]);
      // State in 17:16, core in 9:8, tag in 4:0
      5'h10: host_cmd_rd_data <= {14'd0, port_state[cmd_r.intf.port],
                                  {(8-CW){1'b0}}, rd_desc.core,
                                  {(8-TW){1'b0}}, rd_desc.tag};
      default: host_cmd_rd_data <= 32'hFEFEFEFE;
    endcase
  end

endmodule

// File: hw/slot_scheduler.sv
// ##########################################################################
// Receive slot scheduler top: slot keepers, core selection, port tagging
// ##########################################################################
`include "sched_cfg.svh"

module slot_scheduler
  import sched_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]  rx_tdata,
  input  logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0]  rx_tkeep,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tvalid,
  output logic [`SCHED_IF_COUNT-1:0]                    rx_tready,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tlast,
  output logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]  data_m_tdata,
  output logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0]  data_m_tkeep,
  output id_tag_t [`SCHED_IF_COUNT-1:0]                 data_m_tdest,
  output logic [`SCHED_IF_COUNT*`SCHED_PORT_WIDTH-1:0]  data_m_tuser,
  output logic [`SCHED_IF_COUNT-1:0]                    data_m_tvalid,
  input  logic [`SCHED_IF_COUNT-1:0]                    data_m_tready,
  output logic [`SCHED_IF_COUNT-1:0]                    data_m_tlast,
  input  slot_msg_t                                     ctrl_s_tdata,
  input  logic                                          ctrl_s_tvalid,
  input  logic [`SCHED_CORE_ID_WIDTH-1:0]               ctrl_s_tuser,
  input  host_cmd_t                                     host_cmd,
  input  logic [31:0]                                   host_cmd_wr_data,
  input  logic                                          host_cmd_valid,
  output logic [31:0]                                   host_cmd_rd_data
);

  localparam int C  = `SCHED_CORE_COUNT;
  localparam int IF = `SCHED_IF_COUNT;
  localparam int SW = `SCHED_SLOT_WIDTH;
  localparam int CW = `SCHED_CORE_ID_WIDTH;

  logic [C-1:0]        init_v;
  logic [C-1:0]        ret_v;
  logic [SW-1:0]       slot_value;
  logic [C*SW-1:0]     slot_counts;
  logic [C*SW-1:0]     head_slots;
  logic [C-1:0]        core_pop;
  logic [C-1:0]        income_cores;
  logic [C-1:0]        slots_flush;
  logic [CW-1:0]       sel_core;
  logic [SW-1:0]       sel_slot;
  logic                sel_valid;
  logic                desc_pop;
  logic [IF-1:0]       release_desc;
  port_state_t [IF-1:0] port_state;
  id_tag_t [IF-1:0]    dest_r;

  slot_msg_decode slot_msg_decode_i (
    .clk, .rst_r, .ctrl_s_tdata, .ctrl_s_tvalid, .ctrl_s_tuser,
    .init_v, .ret_v, .slot_value
  );

  for (genvar i = 0; i < C; i++) begin : g_keeper
    slot_keeper slot_keeper_i (
      .clk,
      .rst_r,
      .flush      (slots_flush[i]),
      .init_v     (init_v[i]),
      .ret_v      (ret_v[i]),
      .slot_value,
      .pop        (core_pop[i]),
      .head_slot  (head_slots[i*SW +: SW]),
      .head_valid (),
      .slot_count (slot_counts[i*SW +: SW])
    );
  end

  core_selector core_selector_i (
    .income_cores, .slot_counts, .head_slots, .desc_pop,
    .sel_core, .sel_slot, .sel_valid, .core_pop
  );

  port_dispatcher port_dispatcher_i (
    .clk, .rst_r,
    .rx_tdata, .rx_tkeep, .rx_tvalid, .rx_tlast, .rx_tready,
    .data_m_tdata, .data_m_tkeep, .data_m_tdest, .data_m_tuser,
    .data_m_tvalid, .data_m_tlast, .data_m_tready,
    .sel_core, .sel_slot, .sel_valid, .desc_pop,
    .release_desc, .port_state, .dest_r
  );

  host_cmd_regs host_cmd_regs_i (
    .clk, .rst_r, .host_cmd, .host_cmd_wr_data, .host_cmd_valid, .host_cmd_rd_data,
    .enabled_cores (),
    .income_cores, .slots_flush, .release_desc,
    .slot_counts, .port_state, .dest_r
  );

endmodule

// File: sim/slot_scheduler_sva.sv
// ##########################################################################
// Stream assertions for the slot scheduler: pass-through, tags, uniqueness
// ##########################################################################
`include "sched_cfg.svh"

module slot_scheduler_sva
  import sched_pkg::*;
(
  input logic                                         clk,
  input logic                                         rst_r,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0] rx_tdata,
  input logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0] rx_tkeep,
  input logic [`SCHED_IF_COUNT-1:0]                   rx_tvalid,
  input logic [`SCHED_IF_COUNT-1:0]                   rx_tready,
  input logic [`SCHED_IF_COUNT-1:0]                   rx_tlast,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0] data_m_tdata,
  input logic [`SCHED_IF_COUNT*`SCHED_KEEP_WIDTH-1:0] data_m_tkeep,
  input id_tag_t [`SCHED_IF_COUNT-1:0]                data_m_tdest,
  input logic [`SCHED_IF_COUNT*`SCHED_PORT_WIDTH-1:0] data_m_tuser,
  input logic [`SCHED_IF_COUNT-1:0]                   data_m_tvalid,
  input logic [`SCHED_IF_COUNT-1:0]                   data_m_tready,
  input logic [`SCHED_IF_COUNT-1:0]                   data_m_tlast
);

  localparam int IF = `SCHED_IF_COUNT;
  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = `SCHED_KEEP_WIDTH;
  localparam int PW = `SCHED_PORT_WIDTH;
  localparam int DN = 2 ** $bits(id_tag_t);

  logic [IF-1:0]    moving;
  logic [IF-1:0]    first;
  logic [IF-1:0]    in_pkt;
  id_tag_t [IF-1:0] pkt_dest;
  logic [DN-1:0]    used;

  assign moving = data_m_tvalid & data_m_tready;
  assign first  = moving & ~in_pkt;

  // Descriptors seen so far, none is ever returned in the test
  always_ff @(posedge clk) begin
    if (rst_r) begin
      in_pkt <= '0;
      used   <= '0;
    end else begin
      for (int p = 0; p < IF; p++) begin
        if (first[p]) begin
          used[data_m_tdest[p]] <= 1'b1;
          pkt_dest[p]           <= data_m_tdest[p];
        end
        if (moving[p])
          in_pkt[p] <= !data_m_tlast[p];
      end
    end
  end

  for (genvar p = 0; p < IF; p++) begin : g_port
    a_pass: assert property (@(posedge clk) disable iff (rst_r)
      data_m_tvalid[p] |-> (data_m_tdata[p*DW +: DW] == rx_tdata[p*DW +: DW]) &&
        (data_m_tkeep[p*KW +: KW] == rx_tkeep[p*KW +: KW]) &&
        (data_m_tlast[p] == rx_tlast[p]))
      else $error("stream word differs from rx input on port %0d", p);
    a_user: assert property (@(posedge clk) disable iff (rst_r)
      data_m_tvalid[p] |-> (data_m_tuser[p*PW +: PW] == PW'(p)))
      else $error("tuser is not the port index on port %0d", p);
    a_dest: assert property (@(posedge clk) disable iff (rst_r)
      (moving[p] && in_pkt[p]) |-> (data_m_tdest[p] == pkt_dest[p]))
      else $error("tdest changed inside a packet on port %0d", p);
    a_ready: assert property (@(posedge clk) disable iff (rst_r)
      rx_tready[p] |-> data_m_tready[p])
      else $error("rx_tready high without data_m_tready on port %0d", p);
    a_unique: assert property (@(posedge clk) disable iff (rst_r)
      first[p] |-> !used[data_m_tdest[p]])
      else $error("descriptor reused on port %0d", p);
  end

  a_cross: assert property (@(posedge clk) disable iff (rst_r)
    (first[0] && first[1]) |-> (data_m_tdest[0] != data_m_tdest[1]))
    else $error("both ports started packets with one descriptor");

endmodule

// File: sim/tb_slot_scheduler.sv
// ##########################################################################
// Testbench for the receive slot scheduler: masks, slots, tagging, flush
// ##########################################################################
`include "sched_cfg.svh"

module tb_slot_scheduler
  import sched_pkg::*;
;

  localparam int IF = `SCHED_IF_COUNT;
  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = `SCHED_KEEP_WIDTH;
  localparam int PW = `SCHED_PORT_WIDTH;
  localparam int CW = `SCHED_CORE_ID_WIDTH;
  localparam int TIMEOUT_CYCLES = 3000;

  logic                 clk;
  logic                 rst_r;
  logic [IF*DW-1:0]     rx_tdata;
  logic [IF*KW-1:0]     rx_tkeep;
  logic [IF-1:0]        rx_tvalid;
  logic [IF-1:0]        rx_tready;
  logic [IF-1:0]        rx_tlast;
  logic [IF*DW-1:0]     data_m_tdata;
  logic [IF*KW-1:0]     data_m_tkeep;
  id_tag_t [IF-1:0]     data_m_tdest;
  logic [IF*PW-1:0]     data_m_tuser;
  logic [IF-1:0]        data_m_tvalid;
  logic [IF-1:0]        data_m_tready;
  logic [IF-1:0]        data_m_tlast;
  slot_msg_t            ctrl_s_tdata;
  logic                 ctrl_s_tvalid;
  logic [CW-1:0]        ctrl_s_tuser;
  host_cmd_t            host_cmd;
  logic [31:0]          host_cmd_wr_data;
  logic                 host_cmd_valid;
  logic [31:0]          host_cmd_rd_data;

  logic     bp_en;
  logic     fail_shown;
  logic     run_done;
  int       cycles;
  logic [31:0] rd;

  slot_scheduler slot_scheduler_i (.*);

  bind slot_scheduler slot_scheduler_sva slot_scheduler_sva_i (
    .clk, .rst_r, .rx_tdata, .rx_tkeep, .rx_tvalid, .rx_tready, .rx_tlast,
    .data_m_tdata, .data_m_tkeep, .data_m_tdest, .data_m_tuser,
    .data_m_tvalid, .data_m_tready, .data_m_tlast
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random back-pressure, roughly one stalled cycle in four
  always @(posedge clk) begin
    for (int p = 0; p < IF; p++)
      data_m_tready[p] <= bp_en ? (($urandom % 4) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_shown = 1'b1;
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  final begin
    if (!run_done && !fail_shown)
      $display("SIMULATION FAILED");
  end

  task automatic fail_run();
    fail_shown = 1'b1;
    $display("SIMULATION FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic logic [31:0] cmd_word(input logic wr, input logic if_sel,
                                           input int idx, input int reg_num);
    return {wr, if_sel, 1'b1, 29'd0} | (32'(idx) << 4) | 32'(reg_num);
  endfunction

  task automatic host_write(input logic if_sel, input int idx, input int reg_num,
                            input logic [31:0] data);
    @(posedge clk);
    host_cmd         <= cmd_word(1'b1, if_sel, idx, reg_num);
    host_cmd_wr_data <= data;
    host_cmd_valid   <= 1'b1;
    @(posedge clk);
    host_cmd_valid   <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Read data is valid two edges after the command
  task automatic host_read(input logic if_sel, input int idx, input int reg_num,
                           output logic [31:0] data);
    @(posedge clk);
    host_cmd       <= cmd_word(1'b0, if_sel, idx, reg_num);
    host_cmd_valid <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    data = host_cmd_rd_data;
  endtask

  task automatic slot_init(input int core, input int count);
    @(posedge clk);
    ctrl_s_tdata  <= {4'd3, 12'd0, 4'(count), 16'd0};
    ctrl_s_tuser  <= CW'(core);
    ctrl_s_tvalid <= 1'b1;
    @(posedge clk);
    ctrl_s_tvalid <= 1'b0;
  endtask

  task automatic send_packet(input int p, input int len, output id_tag_t dest);
    dest = '0;
    for (int w = 0; w < len; w++) begin
      @(posedge clk);
      rx_tdata[p*DW +: DW] <= {$urandom, $urandom};
      rx_tkeep[p*KW +: KW] <= '1;
      rx_tlast[p]          <= (w == len - 1);
      rx_tvalid[p]         <= 1'b1;
      do @(negedge clk); while (!rx_tready[p]);
      if (w == 0)
        dest = data_m_tdest[p];
    end
    @(posedge clk);
    rx_tvalid[p] <= 1'b0;
    rx_tlast[p]  <= 1'b0;
  endtask

  task automatic send_burst(input int p, input int count, input logic check_first);
    id_tag_t d;
    for (int i = 0; i < count; i++) begin
      send_packet(p, 1 + ($urandom % 4), d);
      if (check_first && i == 0) begin
        check_eq("data_m_tdest.core", 32'(d.core), 32'd1);
        assert (d.tag >= 1 && d.tag <= 6) else begin
          $display("First packet slot %0d is outside the slots of core 1", d.tag);
          fail_run();
        end
      end
    end
  endtask

  initial begin
    void'($urandom(39496));
    fail_shown       = 1'b0;
    run_done         = 1'b0;
    cycles           = 0;
    bp_en            = 1'b0;
    rst_r            = 1'b1;
    rx_tdata         = '0;
    rx_tkeep         = '0;
    rx_tvalid        = '0;
    rx_tlast         = '0;
    data_m_tready    = '1;
    ctrl_s_tdata     = '0;
    ctrl_s_tvalid    = 1'b0;
    ctrl_s_tuser     = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    repeat (3) @(posedge clk);
    rst_r <= 1'b0;

    // No slots yet, so both ports hold off
    @(posedge clk);
    rx_tvalid <= '1;
    repeat (8) begin
      @(negedge clk);
      check_eq("data_m_tvalid", 32'(data_m_tvalid), 32'd0);
      check_eq("rx_tready", 32'(rx_tready), 32'd0);
    end
    @(posedge clk);
    rx_tvalid <= '0;
    for (int p = 0; p < IF; p++) begin
      host_read(1'b1, p, 0, rd);
      check_eq("port_state", 32'(rd[17:16]), 32'(STALL));
    end

    // Pools filled while no core takes packets
    host_write(1'b0, 0, 0, 32'h3);
    slot_init(0, 3);
    slot_init(1, 6);
    host_read(1'b0, 1, 3, rd);
    check_eq("slot_count[1]", rd, 32'd6);
    host_read(1'b0, 0, 3, rd);
    check_eq("slot_count[0]", rd, 32'd3);

    host_write(1'b0, 0, 1, 32'hF);
    host_read(1'b0, 0, 0, rd);
    check_eq("enabled_cores", rd, 32'h3);
    host_read(1'b0, 0, 1, rd);
    check_eq("income_cores", rd, 32'h3);

    // Nine slots in all, six packets plus two reserved fit
    bp_en <= 1'b1;
    fork
      send_burst(0, 3, 1'b1);
      send_burst(1, 3, 1'b0);
    join
    bp_en <= 1'b0;
    repeat (10) @(posedge clk);

    // Core 0 is drained by now, refill it so its flush shows
    slot_init(0, 3);
    host_write(1'b0, 0, 2, 32'h3);
    host_read(1'b0, 0, 3, rd);
    check_eq("slot_count[0]", rd, 32'd0);
    host_read(1'b0, 1, 3, rd);
    check_eq("slot_count[1]", rd, 32'd0);

    host_write(1'b1, 0, 2, 32'h3);
    for (int p = 0; p < IF; p++) begin
      host_read(1'b1, p, 0, rd);
      check_eq("port_state", 32'(rd[17:16]), 32'(STALL));
    end
    @(posedge clk);
    rx_tvalid <= '1;
    repeat (20) begin
      @(negedge clk);
      check_eq("rx_tready", 32'(rx_tready), 32'd0);
    end

    run_done = 1'b1;
    if (!fail_shown)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/sched_pkg.sv
hw/slot_msg_decode.sv
hw/slot_keeper.sv
hw/core_selector.sv
hw/port_dispatcher.sv
hw/host_cmd_regs.sv
hw/slot_scheduler.sv
sim/slot_scheduler_sva.sv
sim/tb_slot_scheduler.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_slot_scheduler -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
